// File: Makefile
VERILATOR ?= verilator
TOP       ?= long_pipe_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
long_pipe_pkg.sv
long_issue_decode.sv
idiv_iterative.sv
long_wb_ctrl.sv
long_pipe_top.sv
long_pipe_tb.sv

// File: idiv_iterative.sv
`timescale 1ns/10ps
`default_nettype none

module idiv_iterative #(
  parameter int width_p = 64
) (
  input  wire                clk_i,
  input  wire                rst_n_i,
  input  wire                flush_i,
  input  wire                v_i,
  input  wire  [width_p-1:0] dividend_i,
  input  wire  [width_p-1:0] divisor_i,
  input  wire                signed_div_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [width_p-1:0] quotient_o,
  output logic [width_p-1:0] remainder_o,
  input  wire                yumi_i
);

  localparam int cnt_width_lp = $clog2(width_p + 1);

  long_pipe_pkg::idiv_state_e state_r;
  logic [cnt_width_lp-1:0]    cnt_r;

  logic [width_p-1:0] quot_r; // Holds the raw dividend until the load cycle
  logic [width_p-1:0] part_r; // Partial remainder
  logic [width_p-1:0] dvsr_r;
  logic               signed_r;
  logic               neg_quot_r;
  logic               neg_rem_r;
  logic               div_zero_r;

  logic               load_w;
  logic               step_w;
  logic               last_step_w;
  logic               dividend_neg_w;
  logic               divisor_neg_w;
  logic [width_p-1:0] dividend_mag_w;
  logic [width_p-1:0] divisor_mag_w;
  logic [width_p:0]   shift_w;
  logic [width_p:0]   trial_w;
  logic               fits_w;

  assign ready_o = (state_r == long_pipe_pkg::e_idiv_idle);
  assign v_o     = (state_r == long_pipe_pkg::e_idiv_done);

  // Count zero is the load cycle, counts 1 to width_p are the steps
  assign load_w      = (state_r == long_pipe_pkg::e_idiv_busy) && (cnt_r == '0);
  assign step_w      = (state_r == long_pipe_pkg::e_idiv_busy) && (cnt_r != '0);
  assign last_step_w = step_w && (cnt_r == cnt_width_lp'(width_p));

  assign dividend_neg_w = signed_r & quot_r[width_p-1];
  assign divisor_neg_w  = signed_r & dvsr_r[width_p-1];
  assign dividend_mag_w = dividend_neg_w ? -quot_r : quot_r;
  assign divisor_mag_w  = divisor_neg_w ? -dvsr_r : dvsr_r;

  // Each restoring step shifts in the next dividend bit and subtracts if it fits
  assign shift_w = {part_r, quot_r[width_p-1]};
  assign fits_w  = (shift_w >= {1'b0, dvsr_r});
  assign trial_w = shift_w - {1'b0, dvsr_r};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= long_pipe_pkg::e_idiv_idle;
      cnt_r   <= '0;
    end else if (flush_i) begin
      state_r <= long_pipe_pkg::e_idiv_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        long_pipe_pkg::e_idiv_idle: begin
          if (v_i) begin
            state_r <= long_pipe_pkg::e_idiv_busy;
            cnt_r   <= '0;
          end
        end
        long_pipe_pkg::e_idiv_busy: begin
          if (last_step_w) begin
            state_r <= long_pipe_pkg::e_idiv_done;
            cnt_r   <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        long_pipe_pkg::e_idiv_done: begin
          if (yumi_i) state_r <= long_pipe_pkg::e_idiv_idle;
        end
        default: state_r <= long_pipe_pkg::e_idiv_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && v_i) begin
      quot_r   <= dividend_i;
      dvsr_r   <= divisor_i;
      signed_r <= signed_div_i;
    end else if (load_w) begin
      quot_r     <= dividend_mag_w;
      dvsr_r     <= divisor_mag_w;
      part_r     <= '0;
      neg_quot_r <= dividend_neg_w ^ divisor_neg_w;
      neg_rem_r  <= dividend_neg_w; // Remainder takes the dividend's sign
      div_zero_r <= (dvsr_r == '0);
    end else if (step_w) begin
      part_r <= fits_w ? trial_w[width_p-1:0] : shift_w[width_p-1:0];
      quot_r <= {quot_r[width_p-2:0], fits_w};
    end
  end

  // A zero divisor leaves the dividend magnitude in part_r, so the remainder
  // is the dividend after the sign fix
  // Signed overflow wraps back to the most negative value with a zero remainder
  assign quotient_o  = div_zero_r ? '1 : (neg_quot_r ? -quot_r : quot_r);
  assign remainder_o = neg_rem_r ? -part_r : part_r;

endmodule

`default_nettype wire

// File: long_issue_decode.sv
`timescale 1ns/10ps
`default_nettype none

module long_issue_decode #(
  parameter int dword_width_p = 64
) (
  input  wire                          dispatch_v_i,
  input  wire long_pipe_pkg::long_op_e dispatch_op_i,
  input  wire                          dispatch_opw_i,
  input  wire  [dword_width_p-1:0]     dispatch_rs1_i,
  input  wire  [dword_width_p-1:0]     dispatch_rs2_i,
  input  wire                          idiv_ready_i,
  input  wire                          wb_pending_i,
  output logic                         issue_v_o,
  output logic                         signed_div_o,
  output logic [dword_width_p-1:0]     dividend_o,
  output logic [dword_width_p-1:0]     divisor_o,
  output logic                         iready_o
);

  localparam int word_width_lp = long_pipe_pkg::WORD_WIDTH;
  localparam int ext_width_lp  = dword_width_p - word_width_lp;

  logic                     signed_w;
  logic                     rs1_ext_bit_w;
  logic                     rs2_ext_bit_w;
  logic [dword_width_p-1:0] rs1_word_w;
  logic [dword_width_p-1:0] rs2_word_w;

  // DIV and REM are signed, the U forms are not
  assign signed_w = dispatch_op_i inside {long_pipe_pkg::e_long_op_div,
                                          long_pipe_pkg::e_long_op_rem};

  // Only one operation lives in the pipe at a time
  assign issue_v_o = dispatch_v_i & idiv_ready_i & ~wb_pending_i;

  // W forms divide the extended low words on the full datapath
  assign rs1_ext_bit_w = signed_w & dispatch_rs1_i[word_width_lp-1];
  assign rs2_ext_bit_w = signed_w & dispatch_rs2_i[word_width_lp-1];

  always_comb begin
    rs1_word_w = {{ext_width_lp{rs1_ext_bit_w}}, dispatch_rs1_i[word_width_lp-1:0]};
    rs2_word_w = {{ext_width_lp{rs2_ext_bit_w}}, dispatch_rs2_i[word_width_lp-1:0]};
  end

  always_comb begin
    if (dispatch_opw_i) begin
      dividend_o = rs1_word_w;
      divisor_o  = rs2_word_w;
    end else begin
      dividend_o = dispatch_rs1_i;
      divisor_o  = dispatch_rs2_i;
    end
  end

  assign signed_div_o = signed_w;

  // Busy from the dispatch cycle until the result has been taken
  assign iready_o = idiv_ready_i & ~wb_pending_i & ~dispatch_v_i;

endmodule

`default_nettype wire

// File: long_pipe_pkg.sv
`default_nettype none

package long_pipe_pkg;

  // Datapath widths
  localparam int DWORD_WIDTH    = 64;
  localparam int WORD_WIDTH     = 32; // W forms work on the low word
  localparam int REG_ADDR_WIDTH = 5;

  // Integer opcodes handled by the long pipe
  typedef enum logic [1:0] {
    e_long_op_div  = 2'b00,
    e_long_op_divu = 2'b01,
    e_long_op_rem  = 2'b10,
    e_long_op_remu = 2'b11
  } long_op_e;

  // Divider sequencing
  typedef enum logic [1:0] {
    e_idiv_idle = 2'b00,
    e_idiv_busy = 2'b01, // Load cycle followed by one step per quotient bit
    e_idiv_done = 2'b10
  } idiv_state_e;

endpackage

`default_nettype wire

// File: long_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module long_pipe_tb;

  localparam int dword_width_p = long_pipe_pkg::DWORD_WIDTH;
  localparam int addr_width_lp = long_pipe_pkg::REG_ADDR_WIDTH;
  localparam int max_vec_lp    = 64;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  logic                     dispatch_v;
  long_pipe_pkg::long_op_e  dispatch_op;
  logic                     dispatch_opw;
  logic [dword_width_p-1:0] dispatch_rs1;
  logic [dword_width_p-1:0] dispatch_rs2;
  logic [addr_width_lp-1:0] dispatch_rd_addr;
  logic                     iready;
  logic                     iwb_v;
  logic [addr_width_lp-1:0] iwb_rd_addr;
  logic [dword_width_p-1:0] iwb_rd_data;
  logic                     iwb_yumi;

  logic [31:0]              vec_op    [max_vec_lp]; // Raw code so illegal values can be caught
  logic                     vec_opw   [max_vec_lp];
  logic [dword_width_p-1:0] vec_rs1   [max_vec_lp];
  logic [dword_width_p-1:0] vec_rs2   [max_vec_lp];
  logic [addr_width_lp-1:0] vec_rd    [max_vec_lp];
  logic [dword_width_p-1:0] vec_exp   [max_vec_lp];
  logic                     vec_flush [max_vec_lp];

  int   n_vec;
  int   err_cnt;
  int   pass_cnt;
  int   fail_cnt;
  logic test_ok;
  logic loaded;

  long_pipe_top #(
    .dword_width_p(dword_width_p)
  ) dut0 (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .flush_i           (flush),
    .dispatch_v_i      (dispatch_v),
    .dispatch_op_i     (dispatch_op),
    .dispatch_opw_i    (dispatch_opw),
    .dispatch_rs1_i    (dispatch_rs1),
    .dispatch_rs2_i    (dispatch_rs2),
    .dispatch_rd_addr_i(dispatch_rd_addr),
    .iready_o          (iready),
    .iwb_v_o           (iwb_v),
    .iwb_rd_addr_o     (iwb_rd_addr),
    .iwb_rd_data_o     (iwb_rd_data),
    .iwb_yumi_i        (iwb_yumi)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Budget covers the longest test plus reset
  initial begin
    wait (loaded);
    repeat (n_vec * (dword_width_p + 12) + 100) @(posedge clk);
    $display("Timeout: the tests did not finish within the cycle budget");
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_data(input string name, input logic [dword_width_p-1:0] got,
                            input logic [dword_width_p-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_width_lp-1:0] got,
                            input logic [addr_width_lp-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_op(input logic [31:0] code);
    if (code > 32'd3) begin
      $display("Vector holds opcode %h, which is not a long-pipe opcode", code);
      err_cnt++;
      test_ok = 1'b0;
    end
  endtask

  task automatic load_vectors(output logic found);
    int                       fd;
    int                       got;
    string                    line;
    logic [31:0]              op;
    logic [31:0]              opw;
    logic [31:0]              rd;
    logic [31:0]              fl;
    logic [dword_width_p-1:0] rs1;
    logic [dword_width_p-1:0] rs2;
    logic [dword_width_p-1:0] exp;
    n_vec = 0;
    fd    = $fopen("long_pipe_vectors.txt", "r");
    found = (fd != 0);
    if (fd != 0) begin
      while ($fgets(line, fd) > 0 && n_vec < max_vec_lp) begin
        got = $sscanf(line, "%h %h %h %h %h %h %h", op, opw, rs1, rs2, rd, exp, fl);
        if (got == 7) begin // Comment lines do not scan
          vec_op[n_vec]    = op;
          vec_opw[n_vec]   = opw[0];
          vec_rs1[n_vec]   = rs1;
          vec_rs2[n_vec]   = rs2;
          vec_rd[n_vec]    = rd[addr_width_lp-1:0];
          vec_exp[n_vec]   = exp;
          vec_flush[n_vec] = fl[0];
          n_vec++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Result must sit still until yumi
  task automatic check_held(input int i);
    check_flag("iwb_v_o", iwb_v, 1'b1);
    check_flag("iready_o", iready, 1'b0);
    check_data("iwb_rd_data_o", iwb_rd_data, vec_exp[i]);
    check_addr("iwb_rd_addr_o", iwb_rd_addr, vec_rd[i]);
  endtask

  task automatic run_vector(input int i);
    int   cycles;
    int   hold;
    logic seen_v;
    test_ok = 1'b1;
    check_op(vec_op[i]);
    if (test_ok) begin
      while (!iready) step();
      dispatch_v       = 1'b1;
      dispatch_op      = long_pipe_pkg::long_op_e'(vec_op[i][1:0]);
      dispatch_opw     = vec_opw[i];
      dispatch_rs1     = vec_rs1[i];
      dispatch_rs2     = vec_rs2[i];
      dispatch_rd_addr = vec_rd[i];
      #1;
      check_flag("iready_o", iready, 1'b0); // Drops in the dispatch cycle itself
      step();
      dispatch_v = 1'b0;
      if (vec_flush[i]) begin
        repeat (dword_width_p / 4) step();
        flush = 1'b1;
        step();
        flush = 1'b0;
        check_flag("iready_o", iready, 1'b1);
        seen_v = 1'b0;
        repeat (dword_width_p + 2) begin
          seen_v = seen_v | iwb_v;
          step();
        end
        check_flag("iwb_v_o", seen_v, 1'b0);
      end else begin
        cycles = 0;
        while (!iwb_v) begin
          step();
          cycles++;
        end
        check_cycles("iwb_v_o latency", cycles, dword_width_p + 1);
        hold = int'($urandom % 6);
        repeat (hold) begin
          check_held(i);
          step();
        end
        check_held(i);
        iwb_yumi = 1'b1;
        step();
        iwb_yumi = 1'b0;
        check_flag("iready_o", iready, 1'b1);
        check_flag("iwb_v_o", iwb_v, 1'b0);
      end
    end
    if (test_ok) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("Test %0d op %0d w %0b flush %0b: %s", i, vec_op[i], vec_opw[i], vec_flush[i],
             test_ok ? "ok" : "failed");
  endtask

  initial begin
    logic found;
    rst_n            = 1'b0;
    flush            = 1'b0;
    dispatch_v       = 1'b0;
    dispatch_op      = long_pipe_pkg::e_long_op_div;
    dispatch_opw     = 1'b0;
    dispatch_rs1     = '0;
    dispatch_rs2     = '0;
    dispatch_rd_addr = '0;
    iwb_yumi         = 1'b0;
    err_cnt          = 0;
    pass_cnt         = 0;
    fail_cnt         = 0;
    loaded           = 1'b0;
    void'($urandom(32'h48d4));
    load_vectors(found);
    if (!found) begin
      $display("Could not open long_pipe_vectors.txt for reading");
      $display("RESULT: FAIL");
    end else begin
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      #2;
      rst_n   = 1'b1;
      test_ok = 1'b1;
      check_flag("iwb_v_o", iwb_v, 1'b0);
      check_flag("iready_o", iready, 1'b1);
      if (test_ok) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("Test reset state: %s", test_ok ? "ok" : "failed");
      for (int i = 0; i < n_vec; i++) begin
        run_vector(i);
      end
      $display("Tests passed %0d, failed %0d, mismatches %0d", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && n_vec > 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: long_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

module long_pipe_top #(
  parameter int dword_width_p = long_pipe_pkg::DWORD_WIDTH
) (
  input  wire                                      clk_i,
  input  wire                                      rst_n_i,
  input  wire                                      flush_i,
  input  wire                                      dispatch_v_i,
  input  wire long_pipe_pkg::long_op_e             dispatch_op_i,
  input  wire                                      dispatch_opw_i,
  input  wire  [dword_width_p-1:0]                 dispatch_rs1_i,
  input  wire  [dword_width_p-1:0]                 dispatch_rs2_i,
  input  wire  [long_pipe_pkg::REG_ADDR_WIDTH-1:0] dispatch_rd_addr_i,
  output logic                                     iready_o,
  output logic                                     iwb_v_o,
  output logic [long_pipe_pkg::REG_ADDR_WIDTH-1:0] iwb_rd_addr_o,
  output logic [dword_width_p-1:0]                 iwb_rd_data_o,
  input  wire                                      iwb_yumi_i
);

  logic                     issue_v;
  logic                     signed_div;
  logic [dword_width_p-1:0] dividend;
  logic [dword_width_p-1:0] divisor;
  logic                     idiv_ready;
  logic                     idiv_v;
  logic [dword_width_p-1:0] quotient;
  logic [dword_width_p-1:0] remainder;
  logic                     wb_pending;

  long_issue_decode #(
    .dword_width_p(dword_width_p)
  ) decode0 (
    .dispatch_v_i  (dispatch_v_i),
    .dispatch_op_i (dispatch_op_i),
    .dispatch_opw_i(dispatch_opw_i),
    .dispatch_rs1_i(dispatch_rs1_i),
    .dispatch_rs2_i(dispatch_rs2_i),
    .idiv_ready_i  (idiv_ready),
    .wb_pending_i  (wb_pending),
    .issue_v_o     (issue_v),
    .signed_div_o  (signed_div),
    .dividend_o    (dividend),
    .divisor_o     (divisor),
    .iready_o      (iready_o)
  );

  idiv_iterative #(
    .width_p(dword_width_p)
  ) idiv0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .v_i         (issue_v),
    .dividend_i  (dividend),
    .divisor_i   (divisor),
    .signed_div_i(signed_div),
    .ready_o     (idiv_ready),
    .v_o         (idiv_v),
    .quotient_o  (quotient),
    .remainder_o (remainder),
    .yumi_i      (iwb_yumi_i)
  );

  long_wb_ctrl #(
    .dword_width_p(dword_width_p)
  ) wb0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .issue_v_i    (issue_v),
    .op_i         (dispatch_op_i),
    .opw_i        (dispatch_opw_i),
    .rd_addr_i    (dispatch_rd_addr_i),
    .quotient_i   (quotient),
    .remainder_i  (remainder),
    .idiv_v_i     (idiv_v),
    .yumi_i       (iwb_yumi_i),
    .pending_o    (wb_pending),
    .iwb_v_o      (iwb_v_o),
    .iwb_rd_addr_o(iwb_rd_addr_o),
    .iwb_rd_data_o(iwb_rd_data_o)
  );

endmodule

`default_nettype wire

// File: long_pipe_vectors.txt
# op opw rs1 rs2 rd_addr expected flush, all in hex
# op is 0 div, 1 divu, 2 rem, 3 remu and opw selects the W form
0 0 0000000000000064 0000000000000007 01 000000000000000e 0
0 0 ffffffffffffff9c 0000000000000007 02 fffffffffffffff2 0
0 0 0000000000000064 fffffffffffffff9 03 fffffffffffffff2 0
0 0 ffffffffffffff9c fffffffffffffff9 04 000000000000000e 0
2 0 ffffffffffffff9c 0000000000000007 05 fffffffffffffffe 0
2 0 0000000000000064 fffffffffffffff9 06 0000000000000002 0
0 0 8000000000000000 0000000000000002 07 c000000000000000 0
1 0 ffffffffffffff9c 0000000000000010 08 0ffffffffffffff9 0
3 0 ffffffffffffff9c 0000000000000010 09 000000000000000c 0
3 0 123456789abcdef0 0000000100000000 0a 000000009abcdef0 0
0 0 0000000000000064 0000000000000000 0b ffffffffffffffff 0
2 0 ffffffffffffff9c 0000000000000000 0c ffffffffffffff9c 0
3 0 123456789abcdef0 0000000000000000 0d 123456789abcdef0 0
0 0 8000000000000000 ffffffffffffffff 0e 8000000000000000 0
2 0 8000000000000000 ffffffffffffffff 0f 0000000000000000 0
0 0 0000000000000064 0000000000000007 10 0000000000000000 1
0 1 12345678ffffff9c abcdef0000000007 11 fffffffffffffff2 0
1 1 0000000180000000 ffffffff00000002 12 0000000040000000 0
1 1 55555555fffffffe 0000000000000001 13 fffffffffffffffe 0
0 1 0000000080000000 00000000ffffffff 14 ffffffff80000000 0
2 1 00000000ffffff9c 00000000fffffff9 15 fffffffffffffffe 0
3 1 0000000187654321 0000000000000000 16 ffffffff87654321 0
1 1 00000000deadbeef 1234567800000000 17 ffffffffffffffff 0
3 1 00000000deadbeef 0000000000000003 18 0000000000000000 1
1 0 0000000000000064 0000000000000007 1f 000000000000000e 0

// File: long_wb_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module long_wb_ctrl #(
  parameter int dword_width_p = 64
) (
  input  wire                                        clk_i,
  input  wire                                        rst_n_i,
  input  wire                                        flush_i,
  input  wire                                        issue_v_i,
  input  wire long_pipe_pkg::long_op_e               op_i,
  input  wire                                        opw_i,
  input  wire  [long_pipe_pkg::REG_ADDR_WIDTH-1:0]   rd_addr_i,
  input  wire  [dword_width_p-1:0]                   quotient_i,
  input  wire  [dword_width_p-1:0]                   remainder_i,
  input  wire                                        idiv_v_i,
  input  wire                                        yumi_i,
  output logic                                       pending_o,
  output logic                                       iwb_v_o,
  output logic [long_pipe_pkg::REG_ADDR_WIDTH-1:0]   iwb_rd_addr_o,
  output logic [dword_width_p-1:0]                   iwb_rd_data_o
);

  localparam int word_width_lp = long_pipe_pkg::WORD_WIDTH;
  localparam int ext_width_lp  = dword_width_p - word_width_lp;

  logic                                     pending_r;
  long_pipe_pkg::long_op_e                  op_r;
  logic                                     opw_r;
  logic [long_pipe_pkg::REG_ADDR_WIDTH-1:0] rd_addr_r;

  logic                     quot_sel_w;
  logic [dword_width_p-1:0] result_w;

  // A flush drops the operation even if its result is already valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_r <= 1'b0;
    end else if (flush_i) begin
      pending_r <= 1'b0;
    end else if (issue_v_i) begin
      pending_r <= 1'b1;
    end else if (yumi_i) begin
      pending_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_v_i) begin
      op_r      <= op_i;
      opw_r     <= opw_i;
      rd_addr_r <= rd_addr_i;
    end
  end

  assign quot_sel_w = op_r inside {long_pipe_pkg::e_long_op_div,
                                   long_pipe_pkg::e_long_op_divu};
  assign result_w   = quot_sel_w ? quotient_i : remainder_i;

  always_comb begin
    if (opw_r) begin
      // Word results are sign-extended from bit 31 for every W form
      iwb_rd_data_o = {{ext_width_lp{result_w[word_width_lp-1]}},
                       result_w[word_width_lp-1:0]};
    end else begin
      iwb_rd_data_o = result_w;
    end
  end

  assign pending_o     = pending_r;
  assign iwb_v_o       = pending_r & idiv_v_i;
  assign iwb_rd_addr_o = rd_addr_r;

endmodule

`default_nettype wire
